// ==== source/demodPkg.sv ====
// Shared widths, codes and register map for the demod output section
// Addresses are word addresses; bit HalfSelBit picks the upper half of a
// 32-bit register, so each register takes two addresses
package demodPkg;

    // ********************
    // Widths
    localparam int AddrWidth   = 12;
    localparam int BusWidth    = 16;
    localparam int RegWidth    = 2 * BusWidth;
    localparam int SampleWidth = 18;
    localparam int DacWidth    = 14;
    localparam int NumDacs     = 3;
    localparam int ModeWidth   = 4;
    localparam int DacSelWidth = 4;

    // ********************
    // Demod mode codes
    localparam logic [ModeWidth-1:0] ModeFm         = 4'd0;
    localparam logic [ModeWidth-1:0] Mode2Fsk       = 4'd2;
    localparam logic [ModeWidth-1:0] ModePcmTrellis = 4'd8;
    localparam logic [ModeWidth-1:0] ModeSoqpsk     = 4'd9;
    localparam logic [ModeWidth-1:0] ModeMultiH     = 4'd10;

    // DAC select codes owned by the trellis decoders
    localparam logic [DacSelWidth-1:0] DacTrellisI     = 4'd8;
    localparam logic [DacSelWidth-1:0] DacTrellisQ     = 4'd9;
    localparam logic [DacSelWidth-1:0] DacTrellisPhErr = 4'd10;
    localparam logic [DacSelWidth-1:0] DacTrellisIndex = 4'd11;

    // ********************
    // Register map, low half addresses
    localparam logic [AddrWidth-1:0] AddrMiscReset   = 12'h040;
    localparam logic [AddrWidth-1:0] AddrMiscVersion = 12'h044;
    localparam logic [AddrWidth-1:0] AddrMiscClock   = 12'h048;
    localparam logic [AddrWidth-1:0] AddrModeReg     = 12'h100;
    localparam logic [AddrWidth-1:0] AddrDacSelReg   = 12'h104;

    localparam int HalfSelBit = 1;

    localparam logic [BusWidth-1:0] VersionNumber = 16'h0153;

    // Soft reset pulse length in clocks
    localparam int SoftResetCycles = 6;
    localparam int ResetCountWidth = $clog2(SoftResetCycles + 1);

endpackage

// ==== source/demodRegs.sv ====
// Processor register block on a synchronous bus, no wait states
// Read data and rdValid appear exactly one clock after rdEn
// Mode and DAC select writes take effect on the low half address only
`timescale 1ns/1ps

module demodRegs (
    input  logic                             ck933,
    input  logic                             clockCounterEn,
    input  logic [demodPkg::AddrWidth-1:0]   addr,
    input  logic [demodPkg::BusWidth-1:0]    wrData,
    input  logic                             wrEn,
    input  logic                             rdEn,
    input  logic [demodPkg::RegWidth-1:0]    clockHold,
    output logic [demodPkg::BusWidth-1:0]    rdData,
    output logic                             rdValid,
    output logic [demodPkg::ModeWidth-1:0]   demodMode,
    output logic [demodPkg::DacSelWidth-1:0] dac0Select,
    output logic [demodPkg::DacSelWidth-1:0] dac1Select,
    output logic [demodPkg::DacSelWidth-1:0] dac2Select,
    output logic                             clockStart,
    output logic                             resetStrobe,
    output logic                             holdStrobe
);

    logic [demodPkg::AddrWidth-1:0] wordAddr;
    logic [demodPkg::AddrWidth-1:0] rdAddrQ;
    logic [demodPkg::AddrWidth-1:0] rdWordAddr;
    logic [demodPkg::RegWidth-1:0]  rdWord;

    // Register address with the half select stripped
    always_comb begin
        wordAddr = addr;
        wordAddr[demodPkg::HalfSelBit] = 1'b0;
    end

    // Misc space strobes, same cycle as the access
    assign clockStart = wrEn && (wordAddr == demodPkg::AddrMiscClock);
    assign holdStrobe = rdEn && (wordAddr == demodPkg::AddrMiscClock)
                        && !addr[demodPkg::HalfSelBit];

    // ********************
    // Control registers
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            demodMode  <= demodPkg::ModeFm;
            dac0Select <= '0;
            dac1Select <= '0;
            dac2Select <= '0;
        end else if (wrEn && !addr[demodPkg::HalfSelBit]) begin
            if (addr == demodPkg::AddrModeReg) begin
                demodMode <= wrData[demodPkg::ModeWidth-1:0];
            end
            if (addr == demodPkg::AddrDacSelReg) begin
                // Three packed 4-bit fields, channel 0 lowest
                dac0Select <= wrData[3:0];
                dac1Select <= wrData[7:4];
                dac2Select <= wrData[11:8];
            end
        end
    end

    // ********************
    // Read side; the address is captured with rdEn and decoded one clock
    // later, by which time clockHold already carries the snapshot
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            rdValid     <= 1'b0;
            resetStrobe <= 1'b0;
            rdAddrQ     <= '0;
        end else begin
            rdValid     <= rdEn;
            resetStrobe <= rdEn && (wordAddr == demodPkg::AddrMiscReset);
            if (rdEn) begin
                rdAddrQ <= addr;
            end
        end
    end

    always_comb begin
        rdWordAddr = rdAddrQ;
        rdWordAddr[demodPkg::HalfSelBit] = 1'b0;
        case (rdWordAddr)
            demodPkg::AddrMiscVersion: rdWord = {demodPkg::VersionNumber,
                                                 {demodPkg::BusWidth{1'b0}}};
            demodPkg::AddrMiscClock:   rdWord = clockHold;
            demodPkg::AddrModeReg:     rdWord = (demodPkg::RegWidth)'(demodMode);
            demodPkg::AddrDacSelReg:   rdWord = (demodPkg::RegWidth)'({dac2Select,
                                                 dac1Select, dac0Select});
            default:                   rdWord = '0;
        endcase
    end

    // Upper or lower 16 bits by the captured half select
    assign rdData = rdAddrQ[demodPkg::HalfSelBit]
                  ? rdWord[demodPkg::RegWidth-1:demodPkg::BusWidth]
                  : rdWord[demodPkg::BusWidth-1:0];

endmodule

// ==== source/miscControl.sv ====
// Free running 32-bit clock counter, restarted by a bus write
// clockHold is a snapshot taken on a low half read so the two halves match
// coreReset is a fixed SoftResetCycles pulse for the downstream blocks
`timescale 1ns/1ps

module miscControl (
    input  logic                          ck933,
    input  logic                          clockCounterEn,
    input  logic                          clockStart,
    input  logic                          holdStrobe,
    input  logic                          resetStrobe,
    output logic [demodPkg::RegWidth-1:0] clockHold,
    output logic                          coreReset
);

    logic [demodPkg::RegWidth-1:0]        clockCount;
    logic [demodPkg::ResetCountWidth-1:0] resetCount;

    // ********************
    // Cycle counter and snapshot
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            clockCount <= '0;
            clockHold  <= '0;
        end else begin
            if (clockStart) begin
                clockCount <= '0;
            end else begin
                clockCount <= clockCount + 1'b1;
            end
            if (holdStrobe) begin
                clockHold <= clockCount;
            end
        end
    end

    // ********************
    // Soft reset stretcher
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            resetCount <= '0;
        end else if (resetStrobe) begin
            resetCount <= (demodPkg::ResetCountWidth)'(demodPkg::SoftResetCycles);
        end else if (resetCount != '0) begin
            resetCount <= resetCount - 1'b1;
        end
    end

    // High while the down counter runs
    assign coreReset = (resetCount != '0);

endmodule

// ==== source/symbolRouter.sv ====
// Routes symbol strobes and decided bits between legacy and trellis paths
// Gated strobes lag one clock; trellis data lags two, legacy data one
// Lock outputs are active low and purely combinational
`timescale 1ns/1ps

module symbolRouter (
    input  logic                           ck933,
    input  logic                           clockCounterEn,
    input  logic [demodPkg::ModeWidth-1:0] demodMode,
    input  logic iBit, qBit, iSymEn, iSym2xEn, trellisSymSync,
    input  logic bitsyncLock, carrierLock,
    input  logic pcmSymEnIn, pcmSym2xEnIn, pcmBit,
    input  logic soqpskSymEnIn, soqpskSym2xEnIn, soqpskBit,
    input  logic multihLock,
    output logic pcmSymEn, pcmSym2xEn,
    output logic soqpskSymEn, soqpskSym2xEn,
    output logic multihSymEn, multihSym2xEn,
    output logic iData, qData, dataSymEn, dataSym2xEn,
    output logic bsyncNLock, demodNLock
);

    logic pcmMode, soqpskMode, multihMode, fmModes, trellisEn;
    logic trellisBit, trellisSymEn, trellisSym2xEn;

    // ********************
    // Mode decode
    assign pcmMode    = (demodMode == demodPkg::ModePcmTrellis);
    assign soqpskMode = (demodMode == demodPkg::ModeSoqpsk);
    assign multihMode = (demodMode == demodPkg::ModeMultiH);
    assign fmModes    = (demodMode == demodPkg::ModeFm) || (demodMode == demodPkg::Mode2Fsk);
    assign trellisEn  = pcmMode || soqpskMode;

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            pcmSymEn       <= 1'b0;
            pcmSym2xEn     <= 1'b0;
            soqpskSymEn    <= 1'b0;
            soqpskSym2xEn  <= 1'b0;
            multihSymEn    <= 1'b0;
            multihSym2xEn  <= 1'b0;
            trellisBit     <= 1'b0;
            trellisSymEn   <= 1'b0;
            trellisSym2xEn <= 1'b0;
            iData          <= 1'b0;
            qData          <= 1'b0;
            dataSymEn      <= 1'b0;
            dataSym2xEn    <= 1'b0;
        end else begin
            // Strobes to the decoders, only the active one runs
            pcmSymEn      <= trellisSymSync & pcmMode;
            pcmSym2xEn    <= iSym2xEn & pcmMode;
            soqpskSymEn   <= trellisSymSync & soqpskMode;
            soqpskSym2xEn <= iSym2xEn & soqpskMode;
            multihSymEn   <= trellisSymSync & multihMode;
            multihSym2xEn <= iSym2xEn & multihMode;

            // Trellis merge, PCM decisions come out with flipped polarity
            trellisBit     <= pcmMode ? !pcmBit : soqpskBit;
            trellisSymEn   <= pcmMode ? pcmSymEnIn : soqpskSymEnIn;
            trellisSym2xEn <= pcmMode ? pcmSym2xEnIn : soqpskSym2xEnIn;

            // Final bit stream
            if (trellisEn) begin
                iData       <= trellisBit;
                qData       <= trellisBit;
                dataSymEn   <= trellisSymEn;
                dataSym2xEn <= trellisSym2xEn;
            end else begin
                iData       <= fmModes ? !iBit : iBit;
                qData       <= qBit;
                dataSymEn   <= iSymEn;
                dataSym2xEn <= iSym2xEn;
            end
        end
    end

    assign bsyncNLock = !bitsyncLock;
    assign demodNLock = multihMode ? !multihLock : !carrierLock;

endmodule

// ==== source/dacRouter.sv ====
// Three DAC channels, each picks trellis, multi-h or legacy demod samples
// Two clock latency, one sample per clock; pins get the top 14 of 18 bits
`timescale 1ns/1ps

module dacRouter (
    input  logic                             ck933,
    input  logic                             clockCounterEn,
    input  logic [demodPkg::ModeWidth-1:0]   demodMode,
    input  logic [demodPkg::DacSelWidth-1:0] dac0Select, dac1Select, dac2Select,
    input  logic [demodPkg::SampleWidth-1:0] pcmDacData    [demodPkg::NumDacs],
    input  logic                             pcmDacSync    [demodPkg::NumDacs],
    input  logic [demodPkg::SampleWidth-1:0] soqpskDacData [demodPkg::NumDacs],
    input  logic                             soqpskDacSync [demodPkg::NumDacs],
    input  logic [demodPkg::SampleWidth-1:0] multihDacData [demodPkg::NumDacs],
    input  logic                             multihDacSync [demodPkg::NumDacs],
    input  logic                             multihDacEn   [demodPkg::NumDacs],
    input  logic [demodPkg::SampleWidth-1:0] demodDacData  [demodPkg::NumDacs],
    input  logic                             demodDacSync  [demodPkg::NumDacs],
    output logic [demodPkg::DacWidth-1:0]    dac0Data, dac1Data, dac2Data,
    output logic                             dac0Strobe, dac1Strobe, dac2Strobe
);

    logic [demodPkg::DacSelWidth-1:0] dacSel    [demodPkg::NumDacs];
    logic [demodPkg::SampleWidth-1:0] stageData [demodPkg::NumDacs];
    logic                             stageSync [demodPkg::NumDacs];
    logic [demodPkg::DacWidth-1:0]    pinData   [demodPkg::NumDacs];
    logic                             pinStrobe [demodPkg::NumDacs];
    logic                             pcmMode, multihMode;

    function automatic logic isTrellisSel(input logic [demodPkg::DacSelWidth-1:0] sel);
        case (sel)
            demodPkg::DacTrellisI,
            demodPkg::DacTrellisQ,
            demodPkg::DacTrellisPhErr,
            demodPkg::DacTrellisIndex: isTrellisSel = 1'b1;
            default:                   isTrellisSel = 1'b0;
        endcase
    endfunction

    assign dacSel[0]  = dac0Select;
    assign dacSel[1]  = dac1Select;
    assign dacSel[2]  = dac2Select;
    assign pcmMode    = (demodMode == demodPkg::ModePcmTrellis);
    assign multihMode = (demodMode == demodPkg::ModeMultiH);

    // ********************
    // Source select, then pin register
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            for (int ch = 0; ch < demodPkg::NumDacs; ch++) begin
                stageData[ch] <= '0;
                stageSync[ch] <= 1'b0;
                pinData[ch]   <= '0;
                pinStrobe[ch] <= 1'b0;
            end
        end else begin
            for (int ch = 0; ch < demodPkg::NumDacs; ch++) begin
                if (isTrellisSel(dacSel[ch])) begin
                    stageData[ch] <= pcmMode ? pcmDacData[ch] : soqpskDacData[ch];
                    stageSync[ch] <= pcmMode ? pcmDacSync[ch] : soqpskDacSync[ch];
                end else if (multihDacEn[ch] && multihMode) begin
                    stageData[ch] <= multihDacData[ch];
                    stageSync[ch] <= multihDacSync[ch];
                end else begin
                    stageData[ch] <= demodDacData[ch];
                    stageSync[ch] <= demodDacSync[ch];
                end
                // Drop the low LSBs for the 14-bit converters
                pinData[ch]   <= stageData[ch][demodPkg::SampleWidth-1 -: demodPkg::DacWidth];
                pinStrobe[ch] <= stageSync[ch];
            end
        end
    end

    assign dac0Data   = pinData[0];
    assign dac1Data   = pinData[1];
    assign dac2Data   = pinData[2];
    assign dac0Strobe = pinStrobe[0];
    assign dac1Strobe = pinStrobe[1];
    assign dac2Strobe = pinStrobe[2];

endmodule

// ==== source/legacyPassThru.sv ====
// Output and control section of the multi-mode demodulator
// Decoder, multi-h loop and demod outputs arrive as inputs from outside
// clockCounterEn is the asynchronous, active high reset for every register
`timescale 1ns/1ps

module legacyPassThru (
    input  logic                             ck933,
    input  logic                             clockCounterEn,
    // Processor bus
    input  logic [demodPkg::AddrWidth-1:0]   addr,
    input  logic [demodPkg::BusWidth-1:0]    wrData,
    input  logic                             wrEn,
    input  logic                             rdEn,
    output logic [demodPkg::BusWidth-1:0]    rdData,
    output logic                             rdValid,
    output logic                             coreReset,
    // Symbol and bit routing
    input  logic iBit, qBit, iSymEn, iSym2xEn, trellisSymSync,
    input  logic bitsyncLock, carrierLock,
    input  logic pcmSymEnIn, pcmSym2xEnIn, pcmBit,
    input  logic soqpskSymEnIn, soqpskSym2xEnIn, soqpskBit,
    input  logic multihLock,
    output logic pcmSymEn, pcmSym2xEn,
    output logic soqpskSymEn, soqpskSym2xEn,
    output logic multihSymEn, multihSym2xEn,
    output logic iData, qData, dataSymEn, dataSym2xEn,
    output logic bsyncNLock, demodNLock,
    // DAC sources and pins
    input  logic [demodPkg::SampleWidth-1:0] pcmDacData    [demodPkg::NumDacs],
    input  logic                             pcmDacSync    [demodPkg::NumDacs],
    input  logic [demodPkg::SampleWidth-1:0] soqpskDacData [demodPkg::NumDacs],
    input  logic                             soqpskDacSync [demodPkg::NumDacs],
    input  logic [demodPkg::SampleWidth-1:0] multihDacData [demodPkg::NumDacs],
    input  logic                             multihDacSync [demodPkg::NumDacs],
    input  logic                             multihDacEn   [demodPkg::NumDacs],
    input  logic [demodPkg::SampleWidth-1:0] demodDacData  [demodPkg::NumDacs],
    input  logic                             demodDacSync  [demodPkg::NumDacs],
    output logic [demodPkg::DacWidth-1:0]    dac0Data, dac1Data, dac2Data,
    output logic                             dac0Strobe, dac1Strobe, dac2Strobe
);

    // ********************
    // Internal connections
    logic [demodPkg::ModeWidth-1:0]   demodMode;
    logic [demodPkg::DacSelWidth-1:0] dac0Select, dac1Select, dac2Select;
    logic [demodPkg::RegWidth-1:0]    clockHold;
    logic                             clockStart, resetStrobe, holdStrobe;

    // Port names match the nets throughout
    demodRegs demodRegs_i (.*);

    miscControl miscControl_i (.*);

    symbolRouter symbolRouter_i (.*);

    dacRouter dacRouter_i (.*);

endmodule

// ==== test/tbLegacyPassThru.sv ====
// Directed testbench for legacyPassThru
// Inputs change on the rising edge and outputs are checked on the falling edge
// Decoder, multi-h and demod side inputs are plain random stimulus
`timescale 1ns/1ps

module tbLegacyPassThru;

    localparam int ResetCycles = 4;
    localparam int StreamLen   = 12;
    localparam int ClockWait   = 20;
    // Budget per test: reset 100, clock 150, gating 150, data 350, DAC 250
    localparam int TimeoutCycles = 2 * (100 + 150 + 150 + 350 + 250);
    localparam int SrcPcm    = 0;
    localparam int SrcSoqpsk = 1;
    localparam int SrcMultih = 2;
    localparam int SrcDemod  = 3;

    logic ck933 = 1'b0;
    logic clockCounterEn;
    logic [demodPkg::AddrWidth-1:0] addr;
    logic [demodPkg::BusWidth-1:0]  wrData, rdData;
    logic wrEn, rdEn, rdValid, coreReset;
    logic iBit, qBit, iSymEn, iSym2xEn, trellisSymSync, bitsyncLock, carrierLock;
    logic pcmSymEnIn, pcmSym2xEnIn, pcmBit, soqpskSymEnIn, soqpskSym2xEnIn, soqpskBit;
    logic multihLock;
    logic pcmSymEn, pcmSym2xEn, soqpskSymEn, soqpskSym2xEn, multihSymEn, multihSym2xEn;
    logic iData, qData, dataSymEn, dataSym2xEn, bsyncNLock, demodNLock;
    logic [demodPkg::SampleWidth-1:0] pcmDacData [demodPkg::NumDacs];
    logic [demodPkg::SampleWidth-1:0] soqpskDacData [demodPkg::NumDacs];
    logic [demodPkg::SampleWidth-1:0] multihDacData [demodPkg::NumDacs];
    logic [demodPkg::SampleWidth-1:0] demodDacData [demodPkg::NumDacs];
    logic pcmDacSync [demodPkg::NumDacs], soqpskDacSync [demodPkg::NumDacs];
    logic multihDacSync [demodPkg::NumDacs], multihDacEn [demodPkg::NumDacs];
    logic demodDacSync [demodPkg::NumDacs];
    logic [demodPkg::DacWidth-1:0] dac0Data, dac1Data, dac2Data;
    logic dac0Strobe, dac1Strobe, dac2Strobe;
    logic [demodPkg::DacWidth-1:0] pinData [demodPkg::NumDacs];
    logic pinStrobe [demodPkg::NumDacs];

    // Stimulus history, one entry per driven cycle
    // Bits 3:0 data, 6:4 symbol strobes, 9:7 double rate strobes
    logic [9:0] bitHist [StreamLen];
    logic [demodPkg::SampleWidth-1:0] sampleHist [StreamLen][demodPkg::NumDacs][4];
    logic syncHist [StreamLen][demodPkg::NumDacs][4];

    int seed       = 97875;
    int passCount  = 0;
    int errorCount = 0;
    int cycleCount = 0;

    legacyPassThru legacyPassThru_i (.*);

    assign pinData[0]   = dac0Data;
    assign pinData[1]   = dac1Data;
    assign pinData[2]   = dac2Data;
    assign pinStrobe[0] = dac0Strobe;
    assign pinStrobe[1] = dac1Strobe;
    assign pinStrobe[2] = dac2Strobe;

    always #5 ck933 = ~ck933;

    always @(posedge ck933) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run went past %0d clock cycles", TimeoutCycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ********************
    // Compare tasks
    task automatic compareBus(input string name, input logic [demodPkg::BusWidth-1:0] got,
                              input logic [demodPkg::BusWidth-1:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, expected);
            errorCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, expected);
            errorCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic compareSample(input string name, input logic [demodPkg::DacWidth-1:0] got,
                                 input logic [demodPkg::DacWidth-1:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, expected);
            errorCount++;
        end else begin
            passCount++;
        end
    endtask

    task automatic finishTest(input string name, input int startErr);
        $display("%-22s done, %0d errors", name, errorCount - startErr);
    endtask

    // ********************
    // Bus access
    function automatic logic [demodPkg::AddrWidth-1:0] upperHalf(
            input logic [demodPkg::AddrWidth-1:0] a);
        upperHalf = a;
        upperHalf[demodPkg::HalfSelBit] = 1'b1;
    endfunction

    task automatic busWrite(input logic [demodPkg::AddrWidth-1:0] a,
                            input logic [demodPkg::BusWidth-1:0] d);
        @(posedge ck933);
        addr   <= a;
        wrData <= d;
        wrEn   <= 1'b1;
        @(posedge ck933);
        wrEn <= 1'b0;
    endtask

    // Waits for rdValid, which must come exactly one cycle after rdEn
    task automatic busRead(input logic [demodPkg::AddrWidth-1:0] a,
                           output logic [demodPkg::BusWidth-1:0] data);
        int lat;
        lat = 0;
        @(posedge ck933);
        addr <= a;
        rdEn <= 1'b1;
        @(posedge ck933);
        rdEn <= 1'b0;
        do begin
            @(negedge ck933);
            lat++;
        end while (!rdValid && lat < 4);
        if (!rdValid || lat != 1) begin
            $display("Read of address %h at %0t: rdValid not seen one cycle after rdEn",
                     a, $time);
            errorCount++;
        end
        data = rdData;
    endtask

    task automatic setMode(input logic [demodPkg::ModeWidth-1:0] mode);
        busWrite(demodPkg::AddrModeReg, {12'h000, mode});
    endtask

    task automatic initInputs();
        clockCounterEn <= 1'b1;
        addr           <= '0;
        wrData         <= '0;
        wrEn           <= 1'b0;
        rdEn           <= 1'b0;
        {iBit, qBit, iSymEn, iSym2xEn, trellisSymSync} <= 5'b0;
        {bitsyncLock, carrierLock, multihLock} <= 3'b0;
        {pcmSymEnIn, pcmSym2xEnIn, pcmBit} <= 3'b0;
        {soqpskSymEnIn, soqpskSym2xEnIn, soqpskBit} <= 3'b0;
        for (int ch = 0; ch < demodPkg::NumDacs; ch++) begin
            pcmDacData[ch]    <= '0;
            soqpskDacData[ch] <= '0;
            multihDacData[ch] <= '0;
            demodDacData[ch]  <= '0;
            pcmDacSync[ch]    <= 1'b0;
            soqpskDacSync[ch] <= 1'b0;
            multihDacSync[ch] <= 1'b0;
            multihDacEn[ch]   <= 1'b0;
            demodDacSync[ch]  <= 1'b0;
        end
    endtask

    // ********************
    // Tests
    task automatic resetAndVersion();
        logic [demodPkg::BusWidth-1:0] data;
        int startErr;
        startErr = errorCount;
        compareBit("rdValid", rdValid, 1'b0);
        compareBit("coreReset", coreReset, 1'b0);
        compareBit("gated strobes", pcmSymEn | pcmSym2xEn | soqpskSymEn | soqpskSym2xEn
                   | multihSymEn | multihSym2xEn, 1'b0);
        compareBit("dataSymEn", dataSymEn | dataSym2xEn, 1'b0);
        compareBit("DAC strobes", dac0Strobe | dac1Strobe | dac2Strobe, 1'b0);
        busRead(upperHalf(demodPkg::AddrMiscVersion), data);
        compareBus("rdData version high", data, demodPkg::VersionNumber);
        busRead(demodPkg::AddrMiscVersion, data);
        compareBus("rdData version low", data, 16'h0000);
        busRead(12'h200, data);
        compareBus("rdData unmapped", data, 16'h0000);
        busRead(demodPkg::AddrModeReg, data);
        compareBus("rdData mode", data, {12'h000, demodPkg::ModeFm});
        busRead(demodPkg::AddrDacSelReg, data);
        compareBus("rdData DAC select", data, 16'h0000);
        finishTest("reset and version", startErr);
    endtask

    task automatic clockAndSoftReset();
        logic [demodPkg::BusWidth-1:0]   data;
        logic [2*demodPkg::BusWidth-1:0] captured;
        int startErr;
        startErr = errorCount;
        // Count is zero the cycle after the write, so it reads one below the gap
        captured = ClockWait - 1;
        busWrite(demodPkg::AddrMiscClock, 16'h0000);
        repeat (ClockWait - 2) @(posedge ck933);
        busRead(demodPkg::AddrMiscClock, data);
        compareBus("clock count low", data, captured[15:0]);
        busRead(upperHalf(demodPkg::AddrMiscClock), data);
        compareBus("clock count high", data, captured[31:16]);
        busRead(demodPkg::AddrMiscReset, data);
        compareBus("rdData soft reset", data, 16'h0000);
        compareBit("coreReset", coreReset, 1'b0);
        repeat (demodPkg::SoftResetCycles) begin
            @(negedge ck933);
            compareBit("coreReset", coreReset, 1'b1);
        end
        @(negedge ck933);
        compareBit("coreReset", coreReset, 1'b0);
        finishTest("clock and soft reset", startErr);
    endtask

    task automatic modeGating();
        logic [demodPkg::ModeWidth-1:0] modes [5];
        int startErr;
        startErr = errorCount;
        modes = '{demodPkg::ModeFm, demodPkg::Mode2Fsk, demodPkg::ModePcmTrellis,
                  demodPkg::ModeSoqpsk, demodPkg::ModeMultiH};
        for (int m = 0; m < 5; m++) begin
            setMode(modes[m]);
            @(posedge ck933);
            trellisSymSync <= 1'b1;
            iSym2xEn       <= 1'b1;
            @(posedge ck933);
            trellisSymSync <= 1'b0;
            iSym2xEn       <= 1'b0;
            @(negedge ck933);
            compareBit("pcmSymEn", pcmSymEn, modes[m] == demodPkg::ModePcmTrellis);
            compareBit("pcmSym2xEn", pcmSym2xEn, modes[m] == demodPkg::ModePcmTrellis);
            compareBit("soqpskSymEn", soqpskSymEn, modes[m] == demodPkg::ModeSoqpsk);
            compareBit("soqpskSym2xEn", soqpskSym2xEn, modes[m] == demodPkg::ModeSoqpsk);
            compareBit("multihSymEn", multihSymEn, modes[m] == demodPkg::ModeMultiH);
            compareBit("multihSym2xEn", multihSym2xEn, modes[m] == demodPkg::ModeMultiH);
            @(negedge ck933);
            compareBit("gated strobes", pcmSymEn | pcmSym2xEn | soqpskSymEn
                       | soqpskSym2xEn | multihSymEn | multihSym2xEn, 1'b0);
        end
        finishTest("mode gating", startErr);
    endtask

    // Random bits on every bit and strobe input, checked against the path the mode picks
    task automatic streamData(input logic [demodPkg::ModeWidth-1:0] mode);
        logic [31:0] rnd;
        setMode(mode);
        for (int i = 0; i < StreamLen; i++) begin
            @(posedge ck933);
            rnd        = $random(seed);
            bitHist[i] = rnd[9:0];
            pcmBit          <= rnd[0];
            soqpskBit       <= rnd[1];
            iBit            <= rnd[2];
            qBit            <= rnd[3];
            pcmSymEnIn      <= rnd[4];
            soqpskSymEnIn   <= rnd[5];
            iSymEn          <= rnd[6];
            pcmSym2xEnIn    <= rnd[7];
            soqpskSym2xEnIn <= rnd[8];
            iSym2xEn        <= rnd[9];
            @(negedge ck933);
            if (mode == demodPkg::ModePcmTrellis && i >= 2) begin
                compareBit("iData", iData, !bitHist[i-2][0]);
                compareBit("qData", qData, !bitHist[i-2][0]);
                compareBit("dataSymEn", dataSymEn, bitHist[i-2][4]);
                compareBit("dataSym2xEn", dataSym2xEn, bitHist[i-2][7]);
            end else if (mode == demodPkg::ModeSoqpsk && i >= 2) begin
                compareBit("iData", iData, bitHist[i-2][1]);
                compareBit("qData", qData, bitHist[i-2][1]);
                compareBit("dataSymEn", dataSymEn, bitHist[i-2][5]);
                compareBit("dataSym2xEn", dataSym2xEn, bitHist[i-2][8]);
            end else if (mode == demodPkg::ModeFm && i >= 1) begin
                compareBit("iData", iData, !bitHist[i-1][2]);
                compareBit("qData", qData, bitHist[i-1][3]);
                compareBit("dataSymEn", dataSymEn, bitHist[i-1][6]);
                compareBit("dataSym2xEn", dataSym2xEn, bitHist[i-1][9]);
            end
        end
    endtask

    task automatic checkLocks(input logic [demodPkg::ModeWidth-1:0] mode);
        setMode(mode);
        @(posedge ck933);
        multihLock  <= 1'b1;
        carrierLock <= 1'b0;
        bitsyncLock <= 1'b1;
        @(negedge ck933);
        compareBit("demodNLock", demodNLock, mode != demodPkg::ModeMultiH);
        compareBit("bsyncNLock", bsyncNLock, 1'b0);
        @(posedge ck933);
        multihLock  <= 1'b0;
        carrierLock <= 1'b1;
        bitsyncLock <= 1'b0;
        @(negedge ck933);
        compareBit("demodNLock", demodNLock, mode == demodPkg::ModeMultiH);
        compareBit("bsyncNLock", bsyncNLock, 1'b1);
    endtask

    task automatic dataSelection();
        int startErr;
        startErr = errorCount;
        streamData(demodPkg::ModePcmTrellis);
        streamData(demodPkg::ModeSoqpsk);
        streamData(demodPkg::ModeFm);
        checkLocks(demodPkg::ModeMultiH);
        checkLocks(demodPkg::ModeFm);
        finishTest("data selection", startErr);
    endtask

    // Channel 0 is trellis in multi-h mode, so SOQPSK; channel 2 is always demod
    task automatic streamDac(input logic chan1En, input int src1);
        logic [31:0] rnd;
        int src [demodPkg::NumDacs];
        src = '{SrcSoqpsk, src1, SrcDemod};
        for (int i = 0; i < StreamLen; i++) begin
            @(posedge ck933);
            multihDacEn[0] <= 1'b1;
            multihDacEn[1] <= chan1En;
            multihDacEn[2] <= 1'b0;
            for (int ch = 0; ch < demodPkg::NumDacs; ch++) begin
                for (int s = 0; s < 4; s++) begin
                    rnd = $random(seed);
                    sampleHist[i][ch][s] = rnd[demodPkg::SampleWidth-1:0];
                    syncHist[i][ch][s]   = rnd[31];
                end
                pcmDacData[ch]    <= sampleHist[i][ch][SrcPcm];
                pcmDacSync[ch]    <= syncHist[i][ch][SrcPcm];
                soqpskDacData[ch] <= sampleHist[i][ch][SrcSoqpsk];
                soqpskDacSync[ch] <= syncHist[i][ch][SrcSoqpsk];
                multihDacData[ch] <= sampleHist[i][ch][SrcMultih];
                multihDacSync[ch] <= syncHist[i][ch][SrcMultih];
                demodDacData[ch]  <= sampleHist[i][ch][SrcDemod];
                demodDacSync[ch]  <= syncHist[i][ch][SrcDemod];
            end
            @(negedge ck933);
            for (int ch = 0; ch < demodPkg::NumDacs && i >= 2; ch++) begin
                compareSample($sformatf("dac%0dData", ch), pinData[ch],
                    sampleHist[i-2][ch][src[ch]][demodPkg::SampleWidth-1 -: demodPkg::DacWidth]);
                compareBit($sformatf("dac%0dStrobe", ch), pinStrobe[ch],
                    syncHist[i-2][ch][src[ch]]);
            end
        end
    endtask

    task automatic dacRouting();
        int startErr;
        startErr = errorCount;
        setMode(demodPkg::ModeMultiH);
        busWrite(demodPkg::AddrDacSelReg, {4'h0, 4'h0, 4'h0, demodPkg::DacTrellisI});
        streamDac(1'b1, SrcMultih);
        streamDac(1'b0, SrcDemod);
        finishTest("DAC routing", startErr);
    endtask

    initial begin
        initInputs();
        repeat (ResetCycles) @(posedge ck933);
        clockCounterEn <= 1'b0;
        @(negedge ck933);
        resetAndVersion();
        clockAndSoftReset();
        modeGating();
        dataSelection();
        dacRouting();
        $display("Checks passed: %0d, errors: %0d", passCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
source/demodPkg.sv
source/demodRegs.sv
source/miscControl.sv
source/symbolRouter.sv
source/dacRouter.sv
source/legacyPassThru.sv
test/tbLegacyPassThru.sv

// ==== Makefile ====
# Verilator build and run for the demod output section

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= tbLegacyPassThru
DUT       ?= legacyPassThru
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
SRCS      := $(shell cat $(FILELIST))
RTL_SRCS  := $(filter source/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --top-module $(DUT) $(RTL_SRCS)

clean:
	rm -rf $(OBJDIR) $(LOG)
